/* flow_alu_pkg.sv */
// Shared widths, FIFO sizing and the ALU opcode enum for the operand-join pipeline
`default_nettype none

package flow_alu_pkg;

  // --------------------
  // Datapath sizing
  // --------------------

  // Operand and result width, results wrap at this width
  localparam int data_width = 16;

  // --------------------
  // Stream FIFO sizing
  // --------------------

  // Entries per input stream buffer
  localparam int fifo_depth = 4;
  // Read and write pointer width for fifo_depth entries
  localparam int fifo_ptr_width = 2;

  // --------------------
  // Opcodes
  // --------------------

  localparam int op_width = 3;

  // All eight encodings are defined, so no illegal opcode exists
  typedef enum logic [op_width-1:0] {
    op_add    = 3'd0,  // a + b
    op_sub    = 3'd1,  // a - b
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    op_shl    = 3'd5,  // a << b[3:0]
    op_shr    = 3'd6,  // Logical a >> b[3:0]
    op_pass_b = 3'd7
  } alu_op_e;

endpackage : flow_alu_pkg

`default_nettype wire

/* flow_fifo.sv */
// Ready-valid stream FIFO of fixed depth with registered push_ready and pop_valid
`timescale 1ns/100ps
`default_nettype none

module flow_fifo #(
  parameter int width = flow_alu_pkg::data_width
) (
  input  logic             clk,
  input  logic             rst_n,

  // Push side
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [width-1:0] push_data,

  // Pop side
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [width-1:0] pop_data
);

  import flow_alu_pkg::*;

  // --------------------
  // Storage and state
  // --------------------

  // Payload array
  logic [width-1:0] mem [fifo_depth];

  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  // One bit wider than the pointers so a full FIFO is distinct from empty
  logic [fifo_ptr_width:0]   count;

  logic push_xfer;
  logic pop_xfer;

  // --------------------
  // Handshake
  // --------------------

  // Both ready and valid come from the count register only
  assign push_ready = (count != (fifo_ptr_width+1)'(fifo_depth));
  assign pop_valid  = (count != '0);
  // The head entry is always read from the array with no fall-through
  assign pop_data   = mem[rd_ptr];

  assign push_xfer = push_valid && push_ready;
  assign pop_xfer  = pop_valid && pop_ready;

  // Write data at the tail
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_xfer) begin
        wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_xfer) begin
        rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth-1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy stays unchanged when push and pop coincide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push_xfer, pop_xfer})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Occupancy stays within the depth and matches the pointer distance
  count_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (fifo_ptr_width+1)'(fifo_depth) &&
    count[fifo_ptr_width-1:0] == fifo_ptr_width'(wr_ptr - rd_ptr));

  // Upstream must hold valid while the FIFO is full
  push_valid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid && !push_ready |=> push_valid);

endmodule : flow_fifo

`default_nettype wire

/* flow_join.sv */
// Combinational join of several ready-valid flows into one, no datapath
`timescale 1ns/100ps
`default_nettype none

module flow_join #(
  parameter int num_flows = 2  // At least 2
) (
  // Clock and reset feed the checks only
  input  logic                 clk,
  input  logic                 rst_n,

  // Push side, one bit per flow
  input  logic [num_flows-1:0] push_valid,
  output logic [num_flows-1:0] push_ready,

  // Joined pop side
  output logic                 pop_valid,
  input  logic                 pop_ready
);

  // --------------------
  // Join logic
  // --------------------

  // All flows must be present for the joined flow to be valid
  assign pop_valid = &push_valid;

  // Flow i is popped only with every other flow, so its own valid is masked
  // out of the AND before combining with the downstream ready
  for (genvar i = 0; i < num_flows; i++) begin : gen_ready
    assign push_ready[i] = pop_ready &
                           (&(push_valid | (num_flows'(1) << i)));
  end

  // --------------------
  // Checks
  // --------------------

  // Each upstream keeps valid until its item is taken
  for (genvar i = 0; i < num_flows; i++) begin : gen_push_checks
    push_valid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid[i] && !push_ready[i] |=> push_valid[i]);
  end

  // Joined valid survives back-pressure
  pop_valid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid);

endmodule : flow_join

`default_nettype wire

/* flow_alu_stage.sv */
// Registered ALU stage with a ready-valid operand input and result output
`timescale 1ns/100ps
`default_nettype none

module flow_alu_stage (
  input  logic                                clk,
  input  logic                                rst_n,

  // Joined operand triple
  input  logic                                in_valid,
  output logic                                in_ready,
  input  logic [flow_alu_pkg::data_width-1:0] a,
  input  logic [flow_alu_pkg::data_width-1:0] b,
  input  flow_alu_pkg::alu_op_e               op,

  // Result stream
  output logic                                res_valid,
  input  logic                                res_ready,
  output logic [flow_alu_pkg::data_width-1:0] res_data
);

  import flow_alu_pkg::*;

  logic [data_width-1:0] alu_result;
  logic                  load;

  // --------------------
  // Operation
  // --------------------

  // Shift amount comes from the low four bits of b
  always_comb begin
    alu_result = '0;
    case (op)
      op_add:    alu_result = a + b;
      op_sub:    alu_result = a - b;
      op_and:    alu_result = a & b;
      op_or:     alu_result = a | b;
      op_xor:    alu_result = a ^ b;
      op_shl:    alu_result = a << b[3:0];
      op_shr:    alu_result = a >> b[3:0];
      op_pass_b: alu_result = b;
      default:   alu_result = '0;
    endcase
  end

  // --------------------
  // Output register
  // --------------------

  // Accept when empty or when the held result leaves this cycle
  assign in_ready = !res_valid || res_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // Result payload, held until the next load
  always_ff @(posedge clk) begin
    if (load) begin
      res_data <= alu_result;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Stalled result keeps both valid and data
  res_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_data));

endmodule : flow_alu_stage

`default_nettype wire

/* flow_alu_top.sv */
// Top level: three stream FIFOs, the flow join and the registered ALU stage
`timescale 1ns/100ps
`default_nettype none

module flow_alu_top (
  input  logic                                clk,
  input  logic                                rst_n,

  // Operand A stream
  input  logic                                a_valid,
  output logic                                a_ready,
  input  logic [flow_alu_pkg::data_width-1:0] a_data,

  // Operand B stream
  input  logic                                b_valid,
  output logic                                b_ready,
  input  logic [flow_alu_pkg::data_width-1:0] b_data,

  // Opcode stream
  input  logic                                op_valid,
  output logic                                op_ready,
  input  logic [flow_alu_pkg::op_width-1:0]   op_code,

  // Result stream
  output logic                                res_valid,
  input  logic                                res_ready,
  output logic [flow_alu_pkg::data_width-1:0] res_data
);

  import flow_alu_pkg::*;

  // --------------------
  // Internal wiring
  // --------------------

  // FIFO heads, straight to the ALU operands
  logic [data_width-1:0] fifo_a_data;
  logic [data_width-1:0] fifo_b_data;
  logic [op_width-1:0]   fifo_op_data;

  // Join handshake, bit 0 is a, bit 1 is b, bit 2 is op
  logic [2:0] join_push_valid;
  logic [2:0] join_push_ready;

  // Joined triple into the ALU stage
  logic alu_in_valid;
  logic alu_in_ready;

  // --------------------
  // Stream buffers
  // --------------------

  flow_fifo #(.width(data_width)) u_fifo_a (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (a_valid),
    .push_ready (a_ready),
    .push_data  (a_data),
    .pop_valid  (join_push_valid[0]),
    .pop_ready  (join_push_ready[0]),
    .pop_data   (fifo_a_data)
  );

  flow_fifo #(.width(data_width)) u_fifo_b (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (b_valid),
    .push_ready (b_ready),
    .push_data  (b_data),
    .pop_valid  (join_push_valid[1]),
    .pop_ready  (join_push_ready[1]),
    .pop_data   (fifo_b_data)
  );

  // Opcode buffer is only op_width wide
  flow_fifo #(.width(op_width)) u_fifo_op (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (op_valid),
    .push_ready (op_ready),
    .push_data  (op_code),
    .pop_valid  (join_push_valid[2]),
    .pop_ready  (join_push_ready[2]),
    .pop_data   (fifo_op_data)
  );

  // --------------------
  // Join and compute
  // --------------------

  // One item leaves each FIFO only when all three heads are present
  flow_join #(.num_flows(3)) u_join (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (join_push_valid),
    .push_ready (join_push_ready),
    .pop_valid  (alu_in_valid),
    .pop_ready  (alu_in_ready)
  );

  flow_alu_stage u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (alu_in_valid),
    .in_ready  (alu_in_ready),
    .a         (fifo_a_data),
    .b         (fifo_b_data),
    .op        (alu_op_e'(fifo_op_data)),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

endmodule : flow_alu_top

`default_nettype wire

/* flow_alu_tb.sv */
// Testbench for the operand-join ALU pipeline with stimulus, reference model, scoreboard, watchdog
`timescale 1ns/100ps
`default_nettype none

module flow_alu_tb;

  import flow_alu_pkg::*;

  localparam int clk_period   = 20;
  localparam int num_results  = 2000;
  localparam int ops_per_code = 50;
  // Entries in each input stream FIFO
  localparam int stream_depth = 4;
  // Twenty clock cycles per checked result
  localparam int watchdog_ns  = num_results * 20 * clk_period;

  logic                  clk = 1'b0;
  logic                  rst_n = 1'b0;
  logic                  a_valid = 1'b0;
  logic                  a_ready;
  logic [data_width-1:0] a_data = '0;
  logic                  b_valid = 1'b0;
  logic                  b_ready;
  logic [data_width-1:0] b_data = '0;
  logic                  op_valid = 1'b0;
  logic                  op_ready;
  logic [op_width-1:0]   op_code = '0;
  logic                  res_valid;
  logic                  res_ready = 1'b0;
  logic [data_width-1:0] res_data;

  // Stimulus controls written by the sequence only
  int      a_budget = 0;
  int      b_budget = 0;
  int      op_budget = 0;
  int      valid_pct = 80;
  int      res_pct = 70;
  bit      force_op_en = 1'b0;
  alu_op_e force_op = op_add;

  // Driver bookkeeping
  int          a_sent = 0;
  int          b_sent = 0;
  int          op_sent = 0;
  logic [31:0] lcg_state = 32'd65;
  logic [15:0] rnd;

  // Scoreboard state written by the monitor only
  logic [data_width-1:0] a_q[$];
  logic [data_width-1:0] b_q[$];
  alu_op_e               op_q[$];
  bit                    a_acc = 1'b0;
  bit                    b_acc = 1'b0;
  bit                    op_acc = 1'b0;
  int                    acc_a = 0;
  int                    acc_b = 0;
  int                    acc_op = 0;
  int                    results = 0;
  bit                    stall_prev = 1'b0;
  logic [data_width-1:0] held_data;
  logic [data_width-1:0] exp_res;
  logic [data_width-1:0] got_a;
  logic [data_width-1:0] got_b;
  alu_op_e               got_op;

  int expected_total = 0;
  int a_base;
  int b_base;
  int op_base;

  flow_alu_top uut (
    .clk(clk), .rst_n(rst_n),
    .a_valid(a_valid), .a_ready(a_ready), .a_data(a_data),
    .b_valid(b_valid), .b_ready(b_ready), .b_data(b_data),
    .op_valid(op_valid), .op_ready(op_ready), .op_code(op_code),
    .res_valid(res_valid), .res_ready(res_ready), .res_data(res_data)
  );

  always #(clk_period/2) clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  // One LCG step returning its better upper bits
  function automatic logic [15:0] rand_bits();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic bit chance(input int pct);
    return (int'(rand_bits()) % 100) < pct;
  endfunction

  // Operator rules computed wide and cut back to the data width
  function automatic logic [data_width-1:0] expected_result(
    input logic [data_width-1:0] a, input logic [data_width-1:0] b, input alu_op_e op);
    logic [31:0] wide;
    wide = 32'd0;
    case (op)
      op_add:    wide = 32'(a) + 32'(b);
      op_sub:    wide = 32'(a) - 32'(b);
      op_and:    wide = 32'(a & b);
      op_or:     wide = 32'(a | b);
      op_xor:    wide = 32'(a ^ b);
      op_shl:    wide = 32'(a) << b[3:0];
      op_shr:    wide = 32'(a) >> b[3:0];  // Zero fill
      op_pass_b: wide = 32'(b);
      default:   wide = 32'd0;
    endcase
    return wide[data_width-1:0];
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  // Just past the rising edge once the monitor has updated
  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_results(input int target);
    while (results < target) wait_cycle();
  endtask

  // Nothing pending and every accepted triple answered
  task automatic check_drained();
    assert (a_q.size() == 0 && b_q.size() == 0 && op_q.size() == 0) else
      report_error($sformatf("queues not empty: a=%0d b=%0d op=%0d",
                             a_q.size(), b_q.size(), op_q.size()));
    assert (results == acc_a && results == acc_b && results == acc_op) else
      report_error($sformatf("results %0d vs accepted a=%0d b=%0d op=%0d",
                             results, acc_a, acc_b, acc_op));
  endtask

  // --------------------
  // Driver
  // --------------------

  // New item only after the previous one was taken
  always @(negedge clk) begin
    if (rst_n) begin
      if (!a_valid || a_acc) begin
        a_valid = 1'b0;
        if (a_sent < a_budget && chance(valid_pct)) begin
          a_valid = 1'b1;
          a_data = rand_bits();
          a_sent++;
        end
      end
      if (!b_valid || b_acc) begin
        b_valid = 1'b0;
        if (b_sent < b_budget && chance(valid_pct)) begin
          b_valid = 1'b1;
          b_data = rand_bits();
          b_sent++;
        end
      end
      if (!op_valid || op_acc) begin
        op_valid = 1'b0;
        if (op_sent < op_budget && chance(valid_pct)) begin
          rnd = rand_bits();
          op_valid = 1'b1;
          op_code = force_op_en ? force_op : rnd[2:0];
          op_sent++;
        end
      end
      res_ready = chance(res_pct);
    end
  end

  // --------------------
  // Monitor and compare
  // --------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      a_acc = 1'b0;
      b_acc = 1'b0;
      op_acc = 1'b0;
      stall_prev = 1'b0;
    end else begin
      // Stalled result must not move
      if (stall_prev) begin
        assert (res_valid && res_data == held_data) else
          report_error("result valid or data changed while res_ready was low");
      end
      stall_prev = res_valid && !res_ready;
      held_data = res_data;
      if (res_valid && res_ready) begin
        assert (a_q.size() > 0 && b_q.size() > 0 && op_q.size() > 0) else
          report_error("result appeared while an operand stream had nothing pending");
        got_a = a_q.pop_front();
        got_b = b_q.pop_front();
        got_op = op_q.pop_front();
        exp_res = expected_result(got_a, got_b, got_op);
        assert (res_data == exp_res) else
          report_error($sformatf("result %h expected %h (a=%h b=%h op=%s)",
                                 res_data, exp_res, got_a, got_b, got_op.name()));
        results++;
      end
      // Record accepted inputs in order
      a_acc = a_valid && a_ready;
      b_acc = b_valid && b_ready;
      op_acc = op_valid && op_ready;
      if (a_acc) begin
        a_q.push_back(a_data);
        acc_a++;
      end
      if (b_acc) begin
        b_q.push_back(b_data);
        acc_b++;
      end
      if (op_acc) begin
        op_q.push_back(alu_op_e'(op_code));
        acc_op++;
      end
    end
  end

  // --------------------
  // Sequence
  // --------------------

  initial begin
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_cycle();
    assert (a_ready && b_ready && op_ready && !res_valid) else
      report_error("ready or res_valid wrong after reset");

    // Each opcode forced in turn
    force_op_en = 1'b1;
    for (int k = 0; k < 8; k++) begin
      force_op = alu_op_e'(k);
      a_budget += ops_per_code;
      b_budget += ops_per_code;
      op_budget += ops_per_code;
      expected_total += ops_per_code;
      wait_results(expected_total);
    end
    force_op_en = 1'b0;
    check_drained();

    // Operands without an opcode give no result
    a_budget += 5;
    b_budget += 5;
    repeat (30) begin
      wait_cycle();
      assert (!res_valid && results == expected_total) else
        report_error("result appeared with no opcode pending");
    end
    op_budget += 5;
    expected_total += 5;
    wait_results(expected_total);
    check_drained();

    // Full back-pressure, streams pushed continuously
    res_pct = 0;
    valid_pct = 100;
    a_base = acc_a;
    b_base = acc_b;
    op_base = acc_op;
    a_budget += 20;
    b_budget += 20;
    op_budget += 20;
    while (a_ready || b_ready || op_ready) wait_cycle();
    repeat (5) wait_cycle();
    assert (acc_a - a_base == stream_depth + 1 && acc_b - b_base == stream_depth + 1 &&
            acc_op - op_base == stream_depth + 1 && res_valid) else
      report_error($sformatf("accepted under back-pressure a=%0d b=%0d op=%0d",
                             acc_a - a_base, acc_b - b_base, acc_op - op_base));
    res_pct = 100;
    expected_total += 20;
    wait_results(expected_total);
    check_drained();

    // Random traffic up to the full result count
    res_pct = 60;
    valid_pct = 60;
    a_budget += num_results - expected_total;
    b_budget += num_results - expected_total;
    op_budget += num_results - expected_total;
    expected_total = num_results;
    wait_results(expected_total);
    repeat (10) wait_cycle();
    check_drained();

    $display("Simulation passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("TIMEOUT: the run did not finish within %0d ns", watchdog_ns);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule : flow_alu_tb

`default_nettype wire

/* flow_alu.f */
flow_alu_pkg.sv
flow_fifo.sv
flow_join.sv
flow_alu_stage.sv
flow_alu_top.sv
flow_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir
sim_bin=flow_alu_sim

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module flow_alu_tb -f flow_alu.f --Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"

# The log decides, the exit status is only a backup
if grep -q "Simulation failed" "$log_file"; then
  echo "FAIL: failure reported in $log_file"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "FAIL: simulator exited with status $status"
  exit 1
fi
if ! grep -q "Simulation passed" "$log_file"; then
  echo "FAIL: no pass line in $log_file"
  exit 1
fi

echo "PASS"
exit 0
